/* design/vec_pkg.sv */
`default_nettype none

package vec_pkg;

    // instruction geometry
    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 5;   // also the width of vl in commands

    // major opcodes
    localparam logic [6:0] OPC_VLOAD  = 7'h07;  // vle32
    localparam logic [6:0] OPC_VARITH = 7'h57;  // vmacc, vmv, vsetivli
    localparam logic [6:0] OPC_STREAM = 7'h7F;  // custom vstreamout
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    // funct3 under OPC_VARITH
    localparam logic [2:0] F3_VMACC = 3'd0;
    localparam logic [2:0] F3_VMV   = 3'd5;
    localparam logic [2:0] F3_VSET  = 3'd7;

    // wfi is matched on the whole word
    localparam logic [INSTR_W-1:0] WFI_WORD = 32'h1050_0073;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_SPLAT  = 3'd1,
        OP_LOAD   = 3'd2,
        OP_MACC   = 3'd3,
        OP_STREAM = 3'd4,
        OP_WFI    = 3'd5,
        OP_VSET   = 3'd6   // vsetivli, no lane write
    } vec_op_e;

    // decoder output, 23 bits
    typedef struct packed {
        vec_op_e              op;
        logic [REG_IDX_W-1:0] vd;
        logic [REG_IDX_W-1:0] vs1;
        logic [REG_IDX_W-1:0] vs2;  // source of vstreamout too
        logic [4:0]           imm;
    } decoded_t;

    // broadcast to all lanes and the collector
    typedef struct packed {
        logic                 valid;  // one cycle per accepted instruction
        vec_op_e              op;
        logic [REG_IDX_W-1:0] vd;
        logic [REG_IDX_W-1:0] vs1;
        logic [REG_IDX_W-1:0] vs2;
        logic [4:0]           imm;
        logic [REG_IDX_W-1:0] vl;     // lanes below vl are active
    } lane_cmd_t;

endpackage

`default_nettype wire

/* design/isa_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module isa_decoder
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [INSTR_W-1:0]   instr,
    input  logic                 accept_cfg,  // vsetivli accepted this cycle
    output decoded_t             dec,
    output logic [REG_IDX_W-1:0] vl
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    logic is_vmacc;
    logic is_vmv;
    logic is_vset;
    logic is_vload;
    logic is_stream;
    logic is_wfi;

    logic [REG_IDX_W-1:0] req_vl;
    logic [REG_IDX_W-1:0] capped_vl;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // classification
    assign is_vmacc  = (opcode == OPC_VARITH) && (funct3 == F3_VMACC);
    assign is_vmv    = (opcode == OPC_VARITH) && (funct3 == F3_VMV);
    assign is_vset   = (opcode == OPC_VARITH) && (funct3 == F3_VSET);
    assign is_vload  = (opcode == OPC_VLOAD);
    assign is_stream = (opcode == OPC_STREAM);  // ISA extension
    assign is_wfi    = (opcode == OPC_SYSTEM) && (instr == WFI_WORD);

    always_comb begin
        if (is_wfi) begin
            dec.op = OP_WFI;
        end else if (is_vmacc) begin
            dec.op = OP_MACC;
        end else if (is_vmv) begin
            dec.op = OP_SPLAT;
        end else if (is_vset) begin
            dec.op = OP_VSET;
        end else if (is_vload) begin
            dec.op = OP_LOAD;
        end else if (is_stream) begin
            dec.op = OP_STREAM;
        end else begin
            dec.op = OP_NOP;  // unknown words fall through harmlessly
        end
    end

    // field extraction
    assign dec.vd  = instr[11:7];
    assign dec.vs1 = instr[19:15];
    // vstreamout names its source in the rd slot
    assign dec.vs2 = is_stream ? instr[11:7] : instr[24:20];
    assign dec.imm = instr[19:15];

    // requested length is field + 1, never above the lane count
    assign req_vl    = REG_IDX_W'(instr[17:15]) + REG_IDX_W'(1);
    assign capped_vl = (req_vl > REG_IDX_W'(NUM_LANES)) ? REG_IDX_W'(NUM_LANES) : req_vl;

    always_ff @(posedge clk) begin
        if (reset) begin
            vl <= REG_IDX_W'(NUM_LANES);  // all lanes active out of reset
        end else if (accept_cfg) begin
            vl <= capped_vl;
        end
    end

endmodule

`default_nettype wire

/* design/vec_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_issue
    import vec_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    // instruction handshake
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  decoded_t             dec,
    input  logic [REG_IDX_W-1:0] vl,
    output logic                 accept_cfg,

    // load stream handshake
    input  logic                 load_valid,
    output logic                 load_ready,

    input  logic                 collector_busy,
    output lane_cmd_t            lane_cmd,
    output logic                 done
);

    logic is_load;
    logic accepted;

    assign is_load = (dec.op == OP_LOAD);

    // stall while draining, after wfi, or while a load waits for its beat
    assign instr_ready = !collector_busy && !done && !(is_load && !load_valid);

    // load beat moves together with its vle32
    assign load_ready = instr_valid && is_load && !collector_busy && !done;

    assign accepted   = instr_valid && instr_ready;
    assign accept_cfg = accepted && (dec.op == OP_VSET);

    // payload follows the decoder every cycle so lanes can present
    // read data before the stream command is taken
    always_comb begin
        lane_cmd.valid = accepted;
        lane_cmd.op    = dec.op;
        lane_cmd.vd    = dec.vd;
        lane_cmd.vs1   = dec.vs1;
        lane_cmd.vs2   = dec.vs2;
        lane_cmd.imm   = dec.imm;
        lane_cmd.vl    = vl;  // current length, new vl applies from the next command
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (accepted && (dec.op == OP_WFI)) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/vec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane
    import vec_pkg::*;
#(
    parameter int LANE_ID   = 0,
    parameter int DATA_W    = 32,
    parameter int NUM_VREGS = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  lane_cmd_t         cmd,
    input  logic [DATA_W-1:0] load_word,  // this lane's word of the load beat
    output logic [DATA_W-1:0] rd_data
);

    localparam int IDX_W = (NUM_VREGS > 1) ? $clog2(NUM_VREGS) : 1;
    localparam logic [REG_IDX_W-1:0] LANE_IDX = REG_IDX_W'(LANE_ID);

    // element LANE_ID of every vector register
    logic [DATA_W-1:0] vreg [NUM_VREGS];

    logic [IDX_W-1:0]  vd_idx;
    logic [IDX_W-1:0]  vs1_idx;
    logic [IDX_W-1:0]  vs2_idx;
    logic              lane_active;
    logic              wr_en;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] splat_val;
    logic [DATA_W-1:0] macc_val;

    assign vd_idx  = cmd.vd[IDX_W-1:0];
    assign vs1_idx = cmd.vs1[IDX_W-1:0];
    assign vs2_idx = cmd.vs2[IDX_W-1:0];

    assign lane_active = (LANE_IDX < cmd.vl);

    assign splat_val = {{(DATA_W-5){cmd.imm[4]}}, cmd.imm};
    // product wraps to DATA_W
    assign macc_val  = vreg[vd_idx] + vreg[vs1_idx] * vreg[vs2_idx];

    always_comb begin
        wr_en   = 1'b0;
        wr_data = macc_val;
        case (cmd.op)
            OP_SPLAT: begin
                wr_en   = 1'b1;
                wr_data = splat_val;
            end
            OP_LOAD: begin
                wr_en   = 1'b1;
                wr_data = load_word;
            end
            OP_MACC: wr_en = 1'b1;
            default: wr_en = 1'b0;  // nop, stream, wfi, vset
        endcase
        wr_en = wr_en && cmd.valid && lane_active;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                vreg[r] <= '0;
            end
        end else if (wr_en) begin
            vreg[vd_idx] <= wr_data;
        end
    end

    // vstreamout source sits in vs2
    assign rd_data = vreg[vs2_idx];

endmodule

`default_nettype wire

/* design/stream_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_collector
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  lane_cmd_t                         cmd,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]  lane_data,
    output logic [DATA_W-1:0]                 out_data,
    output logic [$clog2(NUM_LANES > 1 ? NUM_LANES : 2)-1:0] out_lane,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic                              busy
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0][DATA_W-1:0] buf_q;  // snapshot of all lanes
    logic [LANE_W-1:0]                idx_q;
    logic [REG_IDX_W-1:0]             vl_q;
    logic                             busy_q;

    logic start;
    logic beat_done;
    logic last_beat;

    assign start     = cmd.valid && (cmd.op == OP_STREAM);
    assign beat_done = out_valid && out_ready;
    assign last_beat = (REG_IDX_W'(idx_q) + REG_IDX_W'(1)) == vl_q;

    // captured once per vstreamout
    always_ff @(posedge clk) begin
        if (start) begin
            buf_q <= lane_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            vl_q   <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
            vl_q   <= cmd.vl;
        end else if (beat_done) begin
            if (last_beat) begin
                busy_q <= 1'b0;  // drain over
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // beat held while out_ready is low
    assign out_valid = busy_q;
    assign out_data  = buf_q[idx_q];
    assign out_lane  = idx_q;
    assign busy      = busy_q;

endmodule

`default_nettype wire

/* design/vec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_core
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = 32,
    parameter int NUM_VREGS = 8
) (
    input  logic                              clk,
    input  logic                              reset,

    // instruction stream
    input  logic [INSTR_W-1:0]                instr,
    input  logic                              instr_valid,
    output logic                              instr_ready,

    // load stream with one word per lane
    input  logic [NUM_LANES-1:0][DATA_W-1:0]  load_data,
    input  logic                              load_valid,
    output logic                              load_ready,

    // output stream
    output logic [DATA_W-1:0]                 out_data,
    output logic [$clog2(NUM_LANES > 1 ? NUM_LANES : 2)-1:0] out_lane,
    output logic                              out_valid,
    input  logic                              out_ready,

    output logic                              done
);

    decoded_t                         dec;
    logic [REG_IDX_W-1:0]             vl;
    logic                             accept_cfg;
    lane_cmd_t                        lane_cmd;
    logic                             collector_busy;
    logic [NUM_LANES-1:0][DATA_W-1:0] lane_rd;

    isa_decoder #(
        .NUM_LANES (NUM_LANES)
    ) u_decoder (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .accept_cfg (accept_cfg),
        .dec        (dec),
        .vl         (vl)
    );

    vec_issue u_issue (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .dec            (dec),
        .vl             (vl),
        .accept_cfg     (accept_cfg),
        .load_valid     (load_valid),
        .load_ready     (load_ready),
        .collector_busy (collector_busy),
        .lane_cmd       (lane_cmd),
        .done           (done)
    );

    // same command to every lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        vec_lane #(
            .LANE_ID   (i),
            .DATA_W    (DATA_W),
            .NUM_VREGS (NUM_VREGS)
        ) u_lane (
            .clk       (clk),
            .reset     (reset),
            .cmd       (lane_cmd),
            .load_word (load_data[i]),
            .rd_data   (lane_rd[i])
        );
    end

    stream_collector #(
        .NUM_LANES (NUM_LANES),
        .DATA_W    (DATA_W)
    ) u_collector (
        .clk       (clk),
        .reset     (reset),
        .cmd       (lane_cmd),
        .lane_data (lane_rd),
        .out_data  (out_data),
        .out_lane  (out_lane),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (collector_busy)
    );

endmodule

`default_nettype wire

/* tb/vec_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_core_chk
    import vec_pkg::*;
(
    input wire logic        clk,
    input wire logic        reset,
    input wire logic [31:0] instr,
    input wire logic        instr_valid,
    input wire logic        instr_ready,
    input wire logic        load_valid,
    input wire logic        load_ready,
    input wire logic [31:0] out_data,
    input wire logic [1:0]  out_lane,
    input wire logic        out_valid,
    input wire logic        out_ready,
    input wire logic        done
);

    int fail_count = 0;  // failed assertions so far

    // idle state right after reset
    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> !out_valid && !load_ready && !done && instr_ready)
        else begin
            $error("state after reset is wrong");
            fail_count++;
        end

    // load beat only moves with its vle32
    a_load_with_instr: assert property (@(posedge clk) disable iff (reset)
        load_valid && load_ready |-> instr_valid && instr_ready)
        else begin
            $error("load beat transferred without its instruction");
            fail_count++;
        end

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_lane))
        else begin
            $error("output beat changed before transfer");
            fail_count++;
        end

    a_no_issue_in_drain: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !instr_ready)
        else begin
            $error("instr_ready high during drain");
            fail_count++;
        end

    a_wfi_done: assert property (@(posedge clk) disable iff (reset)
        instr_valid && instr_ready && (instr == WFI_WORD) |=> done)
        else begin
            $error("done missing after wfi");
            fail_count++;
        end

    // sticky done blocks further instructions
    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done && !instr_ready)
        else begin
            $error("done dropped or instr_ready rose after done");
            fail_count++;
        end

endmodule

bind vec_core vec_core_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .load_valid  (load_valid),
    .load_ready  (load_ready),
    .out_data    (out_data),
    .out_lane    (out_lane),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .done        (done)
);

`default_nettype wire

/* tb/tb_vec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vec_core;

    localparam int NUM_LANES = 4;
    localparam int DATA_W    = 32;
    localparam int NUM_VREGS = 8;
    localparam int MAX_INSTR = 80;
    localparam int INSTR_CYC = 20;    // per instruction incl. load delay
    localparam int DRAIN_CYC = 40;    // per vstreamout with random out_ready
    localparam int MAX_DRAIN = 20;
    localparam time TIMEOUT  = (MAX_INSTR * INSTR_CYC + MAX_DRAIN * DRAIN_CYC) * 10;

    logic                             clk = 1'b0;
    logic                             reset = 1'b1;
    logic [31:0]                      instr = '0;
    logic                             instr_valid = 1'b0;
    logic                             instr_ready;
    logic [NUM_LANES-1:0][DATA_W-1:0] load_data = '0;
    logic                             load_valid = 1'b0;
    logic                             load_ready;
    logic [DATA_W-1:0]                out_data;
    logic [1:0]                       out_lane;
    logic                             out_valid;
    logic                             out_ready = 1'b0;
    logic                             done;

    logic [31:0]       seed = 32'd90;
    logic [DATA_W-1:0] model [NUM_LANES][NUM_VREGS];  // reference registers
    int                vl_m = NUM_LANES;

    vec_core #(
        .NUM_LANES (NUM_LANES),
        .DATA_W    (DATA_W),
        .NUM_VREGS (NUM_VREGS)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .out_data    (out_data),
        .out_lane    (out_lane),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .done        (done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("output stream differs from the reference model");
        end
    endtask

    // reference model, applied on every accepted instruction
    task automatic apply_model(input logic [31:0] w, input logic [NUM_LANES-1:0][DATA_W-1:0] ld);
        logic [6:0] opc;
        logic [2:0] f3;
        int         vd;
        int         vs1;
        int         vs2;
        opc = w[6:0];
        f3  = w[14:12];
        vd  = w[9:7];
        vs1 = w[17:15];
        vs2 = w[22:20];
        for (int l = 0; l < vl_m; l++) begin
            if (opc == 7'h57 && f3 == 3'd5) begin
                model[l][vd] = {{(DATA_W-5){w[19]}}, w[19:15]};
            end else if (opc == 7'h57 && f3 == 3'd0) begin
                model[l][vd] = model[l][vd] + model[l][vs1] * model[l][vs2];
            end else if (opc == 7'h07) begin
                model[l][vd] = ld[l];
            end
        end
        if (opc == 7'h57 && f3 == 3'd7) begin
            vl_m = (w[17:15] + 1 > NUM_LANES) ? NUM_LANES : w[17:15] + 1;
        end
    endtask

    // hold one instruction until accepted; loads raise load_valid after delay cycles
    task automatic issue(input logic [31:0] w, input bit is_load, input int delay);
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b1;
        if (is_load) begin
            repeat (delay) @(posedge clk);
            load_valid <= 1'b1;
        end
        do @(posedge clk); while (!instr_ready || !instr_valid || (is_load && !load_valid));
        apply_model(w, load_data);
        instr_valid <= 1'b0;
        load_valid  <= 1'b0;
    endtask

    task automatic splat(input int vd, input logic [4:0] imm);
        issue({12'd0, imm, 3'd5, 5'(vd), 7'h57}, 1'b0, 0);
    endtask

    task automatic macc(input int vd, input int vs1, input int vs2);
        issue({7'd0, 5'(vs2), 5'(vs1), 3'd0, 5'(vd), 7'h57}, 1'b0, 0);
    endtask

    task automatic set_vl(input int field);
        issue({14'd0, 3'(field), 3'd7, 5'd0, 7'h57}, 1'b0, 0);
    endtask

    task automatic load(input int vd);
        @(posedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            load_data[l] <= lcg_next();
        end
        issue({20'd0, 5'(vd), 7'h07}, 1'b1, lcg_next() % 5);
    endtask

    // vstreamout, then drain with random back-pressure
    task automatic stream(input int vs);
        int beats;
        beats = 0;
        issue({20'd0, 5'(vs), 7'h7F}, 1'b0, 0);
        forever begin
            @(posedge clk);
            if (!out_valid) break;
            if (out_ready) begin
                check_val("out_lane", 32'(out_lane), beats);
                check_val("out_data", out_data, model[beats][vs]);
                beats++;
            end
            out_ready <= lcg_next() % 3 != 0;
        end
        if (beats != vl_m) begin
            stop_with_failure($sformatf("drain gave %0d beats instead of %0d", beats, vl_m));
        end
    endtask

    initial begin
        #(TIMEOUT);
        stop_with_failure("timeout, the DUT stopped making progress");
    end

    always @(posedge clk) begin
        if (UUT.u_chk.fail_count != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    initial begin
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                model[l][r] = '0;
            end
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // splat then random macc chain
        for (int r = 0; r < NUM_VREGS; r++) begin
            splat(r, lcg_next() % 32);
        end
        for (int k = 0; k < 12; k++) begin
            macc(lcg_next() % 8, lcg_next() % 8, lcg_next() % 8);
        end
        for (int r = 0; r < NUM_VREGS; r++) begin
            stream(r);
        end

        load(1);
        load(6);
        macc(6, 1, 6);  // wraps to DATA_W
        stream(1);
        stream(6);

        // shortened vector length
        set_vl(1);
        splat(2, 5'h1B);
        macc(4, 4, 2);
        stream(2);
        set_vl(7);  // capped to NUM_LANES
        stream(2);
        stream(4);

        issue(32'h0000_000B, 1'b0, 0);  // unknown word, no effect
        stream(0);

        issue(32'h1050_0073, 1'b0, 0);
        @(posedge clk);
        if (!done) stop_with_failure("done did not rise after wfi");
        repeat (4) @(posedge clk);

        if (UUT.u_chk.fail_count != 0) begin
            stop_with_failure("a bound assertion failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: vec_core

sources:
  - design/vec_pkg.sv
  - design/isa_decoder.sv
  - design/vec_issue.sv
  - design/vec_lane.sv
  - design/stream_collector.sv
  - design/vec_core.sv
  - target: test
    files:
      - tb/vec_core_chk.sv
      - tb/tb_vec_core.sv

/* tb.f */
design/vec_pkg.sv
design/isa_decoder.sv
design/vec_issue.sv
design/vec_lane.sv
design/stream_collector.sv
design/vec_core.sv
tb/vec_core_chk.sv
tb/tb_vec_core.sv
